// ==== src/gfx_pkg.sv ====
// Graphics package with the video mode, frame buffer geometry and shared structs
package gfx_pkg;

  // Tiny video mode, 64x48 visible in an 80x54 frame
  localparam int H_ACTIVE = 64;
  localparam int H_FRONT  = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BACK   = 4;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  localparam int V_ACTIVE = 48;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 2;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  localparam int H_CNT_W = $clog2(H_TOTAL);
  localparam int V_CNT_W = $clog2(V_TOTAL);
  localparam int X_W     = $clog2(H_ACTIVE);
  localparam int Y_W     = $clog2(V_ACTIVE);

  // Frame buffer striped over banks, pixel i lives in bank i % NUM_STRIPES
  localparam int FB_PIXELS   = H_ACTIVE * V_ACTIVE;
  localparam int FB_ADDR_W   = 12;
  localparam int NUM_STRIPES = 2;
  localparam int BANK_W      = $clog2(NUM_STRIPES);
  localparam int BANK_WORDS  = FB_PIXELS / NUM_STRIPES;
  localparam int BANK_ADDR_W = $clog2(BANK_WORDS);
  localparam int COLOR_W     = 4;

  // Credit loop between reader and output stage
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int ERR_CNT_W  = 16;

  typedef struct packed {
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] grn;
    logic [COLOR_W-1:0] blu;
  } pixel_t;

  typedef struct packed {
    logic                 valid;
    logic [FB_ADDR_W-1:0] addr;
    pixel_t               pix;
  } fb_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [FB_ADDR_W-1:0] addr;
  } fb_rd_t;

  typedef struct packed {
    pixel_t pix;
    logic   hsync;
    logic   vsync;
    logic   de;
  } vga_t;

endpackage

// ==== src/vga_timing.sv ====
// VGA timing generator with registered sync and display enable outputs
`timescale 1ns/1ps

module vga_timing import gfx_pkg::*; (
  input  logic pixel_clk,
  input  logic rst_n,
  input  logic enable,
  output logic hsync,
  output logic vsync,
  output logic de
);

  logic [H_CNT_W-1:0] h_cnt;
  logic [V_CNT_W-1:0] v_cnt;
  logic               h_last;
  logic               v_last;

  assign h_last = (h_cnt == H_CNT_W'(H_TOTAL - 1));
  assign v_last = (v_cnt == V_CNT_W'(V_TOTAL - 1));

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (!enable) begin
      // Parked at the top left until the frame buffer is filled
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // Decode from the current count, outputs appear one cycle later
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      de    <= 1'b0;
    end else begin
      hsync <= !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
      vsync <= !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
      de    <= enable && (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    end
  end

  a_cnt_range: assert property (
    @(posedge pixel_clk) disable iff (!rst_n)
    (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL)
  ) else $error("vga_timing counter out of range h=%0d v=%0d", h_cnt, v_cnt);

endmodule

// ==== src/fb_filler.sv ====
// Frame buffer filler that writes the stripe test pattern once after reset
`timescale 1ns/1ps

module fb_filler import gfx_pkg::*; (
  input  logic   pixel_clk,
  input  logic   rst_n,
  output fb_wr_t wr,
  output logic   fill_done
);

  logic [X_W-1:0]       x;
  logic [Y_W-1:0]       y;
  logic [FB_ADDR_W-1:0] idx;
  logic                 wr_valid;
  logic [FB_ADDR_W-1:0] wr_addr;
  pixel_t               wr_pix;
  logic                 last_wr;

  assign last_wr = wr_valid && (wr_addr == FB_ADDR_W'(FB_PIXELS - 1));
  assign wr      = '{valid: wr_valid, addr: wr_addr, pix: wr_pix};

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      x         <= '0;
      y         <= '0;
      idx       <= '0;
      wr_valid  <= 1'b0;
      fill_done <= 1'b0;
    end else if (!fill_done) begin
      if (last_wr) begin
        // Last pixel lands in memory on this edge
        wr_valid  <= 1'b0;
        fill_done <= 1'b1;
      end else begin
        wr_valid <= 1'b1;
        idx      <= idx + 1'b1;
        if (x == X_W'(H_ACTIVE - 1)) begin
          x <= '0;
          y <= y + 1'b1;
        end else begin
          x <= x + 1'b1;
        end
      end
    end
  end

  // Pattern colour for the pixel at (x, y)
  always_ff @(posedge pixel_clk) begin
    wr_addr    <= idx;
    wr_pix.red <= x[COLOR_W-1:0];
    wr_pix.grn <= y[COLOR_W-1:0];
    wr_pix.blu <= COLOR_W'(x[X_W-1:3]) + COLOR_W'(y[Y_W-1:3]);
  end

endmodule

// ==== src/fb_stripe_mem.sv ====
// Frame buffer built from interleaved stripe banks with one write and one read port
`timescale 1ns/1ps

module fb_stripe_mem import gfx_pkg::*; (
  input  logic   pixel_clk,
  input  fb_wr_t wr,
  input  fb_rd_t rd,
  output pixel_t rd_data,
  output logic   rd_valid
);

  logic [BANK_W-1:0]      wr_bank;
  logic [BANK_ADDR_W-1:0] wr_word;
  logic [BANK_W-1:0]      rd_bank;
  logic [BANK_ADDR_W-1:0] rd_word;
  logic [BANK_W-1:0]      rd_bank_q;
  pixel_t                 bank_q [NUM_STRIPES];

  // Low bits pick the stripe, the rest is the word inside it
  assign wr_bank = BANK_W'(wr.addr % NUM_STRIPES);
  assign wr_word = BANK_ADDR_W'(wr.addr / NUM_STRIPES);
  assign rd_bank = BANK_W'(rd.addr % NUM_STRIPES);
  assign rd_word = BANK_ADDR_W'(rd.addr / NUM_STRIPES);

  for (genvar b = 0; b < NUM_STRIPES; b++) begin : g_bank
    pixel_t mem [BANK_WORDS];

    always_ff @(posedge pixel_clk) begin
      if (wr.valid && (wr_bank == BANK_W'(b))) begin
        mem[wr_word] <= wr.pix;
      end
      if (rd.valid && (rd_bank == BANK_W'(b))) begin
        bank_q[b] <= mem[rd_word];
      end
    end
  end

  always_ff @(posedge pixel_clk) begin
    rd_valid  <= rd.valid;
    rd_bank_q <= rd_bank;
  end

  assign rd_data = bank_q[rd_bank_q];

  // Reads only start once the filler has stopped writing
  a_no_rd_during_fill: assert property (
    @(posedge pixel_clk) rd.valid |-> !wr.valid
  ) else $error("fb_stripe_mem read issued while the buffer is still being filled");

endmodule

// ==== src/scan_reader.sv ====
// Raster scan reader that spends credits on frame buffer reads and forwards the data
`timescale 1ns/1ps

module scan_reader import gfx_pkg::*; (
  input  logic   pixel_clk,
  input  logic   rst_n,
  input  logic   start,
  input  logic   credit_return,
  output fb_rd_t rd,
  input  pixel_t mem_data,
  input  logic   mem_valid,
  output logic   push,
  output pixel_t push_data
);

  logic [FIFO_CNT_W-1:0] credits;
  logic [FB_ADDR_W-1:0]  rd_addr;
  logic                  issue;
  logic                  addr_last;

  // One read per cycle while any credit is held
  assign issue     = start && (credits != '0);
  assign addr_last = (rd_addr == FB_ADDR_W'(FB_PIXELS - 1));
  assign rd        = '{valid: issue, addr: rd_addr};

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      credits <= FIFO_CNT_W'(FIFO_DEPTH);
      rd_addr <= '0;
    end else begin
      credits <= credits - FIFO_CNT_W'(issue) + FIFO_CNT_W'(credit_return);
      if (issue) begin
        // Wrap into the next frame
        rd_addr <= addr_last ? '0 : rd_addr + 1'b1;
      end
    end
  end

  // Every credit spent reserves a FIFO slot for the response
  assign push      = mem_valid;
  assign push_data = mem_data;

  a_credit_bound: assert property (
    @(posedge pixel_clk) disable iff (!rst_n)
    credits <= FIFO_CNT_W'(FIFO_DEPTH)
  ) else $error("scan_reader holds %0d credits, more than FIFO depth", credits);

endmodule

// ==== src/pixel_fifo.sv ====
// Pixel FIFO between the frame buffer reader and the VGA output stage
`timescale 1ns/1ps

module pixel_fifo import gfx_pkg::*; (
  input  logic   pixel_clk,
  input  logic   rst_n,
  input  logic   push,
  input  pixel_t push_data,
  input  logic   pop,
  output pixel_t pop_data,
  output logic   empty
);

  pixel_t                mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  bypass;
  logic                  wr_en;
  logic                  rd_en;

  // Empty FIFO passes the incoming pixel straight through
  assign bypass   = (count == '0);
  assign empty    = bypass && !push;
  assign pop_data = bypass ? push_data : mem[rd_ptr];
  assign wr_en    = push && !(pop && bypass);
  assign rd_en    = pop && !bypass;

  always_ff @(posedge pixel_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + FIFO_PTR_W'(wr_en);
      rd_ptr <= rd_ptr + FIFO_PTR_W'(rd_en);
      count  <= count + FIFO_CNT_W'(wr_en) - FIFO_CNT_W'(rd_en);
    end
  end

  // Credit accounting upstream keeps room for every response
  a_no_overflow: assert property (
    @(posedge pixel_clk) disable iff (!rst_n)
    push |-> (count < FIFO_CNT_W'(FIFO_DEPTH))
  ) else $error("pixel_fifo push while full");

endmodule

// ==== src/vga_out.sv ====
// VGA output stage that pops pixels, returns credits and counts underflows
`timescale 1ns/1ps

module vga_out import gfx_pkg::*; (
  input  logic                 pixel_clk,
  input  logic                 rst_n,
  input  logic                 hsync,
  input  logic                 vsync,
  input  logic                 de,
  input  logic                 fifo_empty,
  input  pixel_t               fifo_data,
  output logic                 pop,
  output logic                 credit_return,
  output vga_t                 vga,
  output logic [ERR_CNT_W-1:0] error_cnt
);

  logic underflow;

  assign pop           = de && !fifo_empty;
  assign credit_return = pop;
  assign underflow     = de && fifo_empty;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      vga       <= '{pix: pixel_t'(0), hsync: 1'b1, vsync: 1'b1, de: 1'b0};
      error_cnt <= '0;
    end else begin
      vga.hsync <= hsync;
      vga.vsync <= vsync;
      vga.de    <= de;
      // Black in blanking and on a missed pixel
      vga.pix   <= pop ? fifo_data : pixel_t'(0);
      if (underflow && (error_cnt != '1)) begin
        error_cnt <= error_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== src/gfx_stripe_top.sv ====
// Striped frame buffer graphics top with pattern fill and VGA scan-out
`timescale 1ns/1ps

module gfx_stripe_top import gfx_pkg::*; (
  input  logic                 pixel_clk,
  input  logic                 rst_n,
  output vga_t                 vga,
  output logic                 fill_done,
  output logic [ERR_CNT_W-1:0] error_cnt
);

  fb_wr_t fb_wr;
  fb_rd_t fb_rd;
  pixel_t mem_data;
  logic   mem_valid;
  logic   push;
  pixel_t push_data;
  logic   pop;
  pixel_t pop_data;
  logic   fifo_empty;
  logic   credit_return;
  logic   hsync;
  logic   vsync;
  logic   de;

  vga_timing vga_timing_inst (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .enable    (fill_done),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de)
  );

  fb_filler fb_filler_inst (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .wr        (fb_wr),
    .fill_done (fill_done)
  );

  fb_stripe_mem fb_stripe_mem_inst (
    .pixel_clk (pixel_clk),
    .wr        (fb_wr),
    .rd        (fb_rd),
    .rd_data   (mem_data),
    .rd_valid  (mem_valid)
  );

  scan_reader scan_reader_inst (
    .pixel_clk     (pixel_clk),
    .rst_n         (rst_n),
    .start         (fill_done),
    .credit_return (credit_return),
    .rd            (fb_rd),
    .mem_data      (mem_data),
    .mem_valid     (mem_valid),
    .push          (push),
    .push_data     (push_data)
  );

  pixel_fifo pixel_fifo_inst (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (fifo_empty)
  );

  vga_out vga_out_inst (
    .pixel_clk     (pixel_clk),
    .rst_n         (rst_n),
    .hsync         (hsync),
    .vsync         (vsync),
    .de            (de),
    .fifo_empty    (fifo_empty),
    .fifo_data     (pop_data),
    .pop           (pop),
    .credit_return (credit_return),
    .vga           (vga),
    .error_cnt     (error_cnt)
  );

endmodule

// ==== bench/tb_gfx_stripe.sv ====
// Testbench for the striped frame buffer graphics top that checks scan-out against pattern data
`timescale 1ns/1ps

module tb_gfx_stripe import gfx_pkg::*; ();

  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 4;
  localparam int NUM_ENTRIES = 19;
  localparam int WATCHDOG_CYCLES =
    2 * (RST_CYCLES + FB_PIXELS + 3 * H_TOTAL * V_TOTAL);

  logic                 pixel_clk;
  logic                 rst_n;
  vga_t                 vga;
  logic                 fill_done;
  logic [ERR_CNT_W-1:0] error_cnt;

  // Frame in [27:24], pixel index in [23:12], colour in [11:0]
  logic [27:0] testdata [NUM_ENTRIES];

  gfx_stripe_top gfx_stripe_top_inst (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .vga       (vga),
    .fill_done (fill_done),
    .error_cnt (error_cnt)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  initial begin
    pixel_clk = 1'b0;
    forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge pixel_clk);
    @(negedge pixel_clk);
    rst_n = 1'b1;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: two frames were not scanned out in time");
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : monitor
    int unsigned pix_cnt;
    int unsigned hs_cnt;
    int unsigned frame;
    int unsigned matched;
    logic        prev_hsync;
    logic        prev_vsync;
    logic        filled;
    pix_cnt    = 0;
    hs_cnt     = 0;
    frame      = 0;
    matched    = 0;
    prev_hsync = 1'b1;
    prev_vsync = 1'b1;
    filled     = 1'b0;
    $readmemh("bench/gfx_testdata.hex", testdata);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if ($isunknown(testdata[i])) begin
        $display("Test data file is missing entries or holds invalid words");
        $display("Testbench failed");
        $fatal(1, "bad test data");
      end
    end
    @(posedge rst_n);
    check_value("fill_done", fill_done, 1'b0);
    while (frame < 2) begin
      @(negedge pixel_clk);
      check_value("error_cnt", error_cnt, '0);
      // fill_done holds once it has risen
      if (filled) begin
        check_value("fill_done", fill_done, 1'b1);
      end
      filled = filled | fill_done;
      // Outputs stay in reset state until the buffer is filled
      if (!fill_done) begin
        check_value("vga.hsync", vga.hsync, 1'b1);
        check_value("vga.vsync", vga.vsync, 1'b1);
        check_value("vga.de", vga.de, 1'b0);
      end
      if (!vga.de) begin
        check_value("vga.pix", vga.pix, '0);
      end else begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
          if ((testdata[i][27:24] == frame) && (testdata[i][23:12] == pix_cnt)) begin
            check_value("vga.pix", vga.pix, testdata[i][11:0]);
            matched++;
          end
        end
        pix_cnt++;
      end
      if (prev_hsync && !vga.hsync) begin
        hs_cnt++;
      end
      if (prev_vsync && !vga.vsync) begin
        check_value("de cycles per frame", pix_cnt, FB_PIXELS);
        // First vsync period is only partly seen
        if (frame > 0) begin
          check_value("hsync pulses per frame", hs_cnt, V_TOTAL);
        end
        frame++;
        pix_cnt = 0;
        hs_cnt  = 0;
      end
      prev_hsync = vga.hsync;
      prev_vsync = vga.vsync;
    end
    if (matched != NUM_ENTRIES) begin
      $display("Only %0d of %0d test data entries were reached", matched, NUM_ENTRIES);
      $display("Testbench failed");
      $fatal(1, "incomplete coverage of test data");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
src/gfx_pkg.sv
src/vga_timing.sv
src/fb_filler.sv
src/fb_stripe_mem.sv
src/scan_reader.sv
src/pixel_fifo.sv
src/vga_out.sv
src/gfx_stripe_top.sv
bench/tb_gfx_stripe.sv

// ==== bench/gfx_testdata.hex ====
// frame_index_colour: frame (1 digit), linear pixel index (3 digits),
// expected colour as red, grn, blu (3 digits)
0_000_000
0_001_100
0_009_901
0_03f_f07
0_040_010
0_081_120
0_3e8_8f6
0_4d2_234
0_7ff_ffa
0_800_004
0_9fb_b7b
0_bfe_efc
0_bff_ffc
1_000_000
1_001_100
1_002_200
1_201_181
1_3e8_8f6
1_bff_ffc
